// ==== fifo_golden.txt ====
// columns in hex: op count word first_byte level_after
// op 0 idle, 1 write, 2 read, 3 write and read, 4 write while full, 5 read while empty, f end
// each further word adds 04040404, each further expected byte adds one
0 2 00000000 00 00
5 2 00000000 00 00
// one word out as four bytes, lsb first
1 1 03020100 00 04
2 4 00000000 00 00
5 1 00000000 00 00
// fill to 64 bytes across the word pointer wrap
1 10 13121110 00 40
4 2 deadbeef 00 40
2 3 00000000 10 3d
4 1 cafef00d 00 3d
2 1 00000000 13 3c
2 20 00000000 14 1c
// push and pop on the same edge, plus four minus one
3 4 53525150 34 28
// drain across the read pointer wrap
2 28 00000000 38 00
5 2 00000000 00 00
0 2 00000000 00 00
f 0 00000000 00 00

// ==== project.f ====
fifo_geom_pkg.sv
fifo_types_pkg.sv
fifo_wr_ptr.sv
fifo_rd_ptr.sv
fifo_level_flags.sv
fifo_ram_2p_asym.sv
fifo_sync_asym.sv
fifo_sync_asym_chk.sv
tb_clk_gen.sv
tb_fifo_monitor.sv
tb_fifo_sync_asym.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_fifo_sync_asym
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass or fail is taken from the simulation output
sim: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_fifo_sync_asym.sv ====
`timescale 1ns/1ps

module tb_fifo_sync_asym
   import fifo_geom_pkg::*;
   import fifo_types_pkg::*;
();

   localparam string GOLDEN_FILE = "fifo_golden.txt";
   localparam int MAX_OPS = 64;
   localparam int FIELDS = 5;
   localparam int WAIT_LIMIT = 200;
   localparam int RESET_CYCLES = 16;
   // next word carries the next four byte values
   localparam w_word_t WORD_STEP = 32'h0404_0404;

   localparam logic [3:0] OP_IDLE = 4'h0;
   localparam logic [3:0] OP_WRITE = 4'h1;
   localparam logic [3:0] OP_READ = 4'h2;
   localparam logic [3:0] OP_BOTH = 4'h3;
   localparam logic [3:0] OP_WR_FULL = 4'h4;
   localparam logic [3:0] OP_RD_EMPTY = 4'h5;
   localparam logic [3:0] OP_END = 4'hf;

   logic    clk;
   logic    rst_n;
   logic    w_en;
   w_word_t w_data;
   logic    w_full;
   level_t  w_level;
   logic    r_en;
   r_byte_t r_data;
   logic    r_empty;
   level_t  r_level;

   // expectations handed to the monitor
   logic    exp_valid;
   r_byte_t exp_byte;
   logic    lvl_valid;
   level_t  exp_level;

   logic [31:0] gold [MAX_OPS*FIELDS];
   int tb_errs;
   int mon_errs;
   int pending;
   int assert_fails;

   tb_clk_gen i_tb_clk_gen (
      .clk (clk)
   );

   fifo_sync_asym i_fifo_sync_asym (
      .clk     (clk),
      .rst_n   (rst_n),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .w_level (w_level),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .r_level (r_level)
   );

   tb_fifo_monitor i_tb_fifo_monitor (
      .clk       (clk),
      .rst_n     (rst_n),
      .w_en      (w_en),
      .r_en      (r_en),
      .w_full    (w_full),
      .r_empty   (r_empty),
      .w_level   (w_level),
      .r_level   (r_level),
      .r_data    (r_data),
      .exp_valid (exp_valid),
      .exp_byte  (exp_byte),
      .lvl_valid (lvl_valid),
      .exp_level (exp_level),
      .err_cnt   (mon_errs),
      .pending   (pending)
   );

   bind fifo_sync_asym fifo_sync_asym_chk i_fifo_sync_asym_chk (
      .clk    (clk),
      .rst_n  (rst_n),
      .full   (full),
      .empty  (empty),
      .w_push (w_push),
      .r_pop  (r_pop),
      .level  (level)
   );

   // one clock cycle of inputs applied 1 ns after the rising edge
   task automatic drive_cycle(input logic we, input logic re, input w_word_t wd,
                              input logic ev, input r_byte_t eb,
                              input logic lv, input level_t el);
      w_en = we;
      r_en = re;
      w_data = wd;
      exp_valid = ev;
      exp_byte = eb;
      lvl_valid = lv;
      exp_level = el;
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycle();
      drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
   endtask

   task automatic run_line(input logic [3:0] op, input int cnt, input w_word_t word,
                           input r_byte_t first, input level_t lvl);
      int n;
      logic last;
      w_word_t wd;
      r_byte_t eb;
      n = 0;
      // blocked operations are only meaningful once the flag is up
      if (op == OP_WR_FULL) begin
         while (!w_full && n < WAIT_LIMIT) begin
            idle_cycle();
            n++;
         end
         if (!w_full) begin
            $display("timeout: w_full never rose before the blocked write");
            tb_errs++;
         end
      end
      if (op == OP_RD_EMPTY) begin
         while (!r_empty && n < WAIT_LIMIT) begin
            idle_cycle();
            n++;
         end
         if (!r_empty) begin
            $display("timeout: r_empty never rose before the blocked read");
            tb_errs++;
         end
      end
      for (int i = 0; i < cnt; i++) begin
         last = (i == cnt - 1);
         wd = word + w_word_t'(i) * WORD_STEP;
         eb = first + r_byte_t'(i);
         case (op)
            OP_IDLE:     drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, last, lvl);
            OP_WRITE:    drive_cycle(1'b1, 1'b0, wd, 1'b0, '0, last, lvl);
            OP_READ:     drive_cycle(1'b0, 1'b1, '0, 1'b1, eb, last, lvl);
            OP_BOTH:     drive_cycle(1'b1, 1'b1, wd, 1'b1, eb, last, lvl);
            OP_WR_FULL:  drive_cycle(1'b1, 1'b0, word, 1'b0, '0, last, lvl);
            OP_RD_EMPTY: drive_cycle(1'b0, 1'b1, '0, 1'b0, '0, last, lvl);
            default: begin
               $display("golden file holds unknown operation %0h", op);
               tb_errs++;
            end
         endcase
      end
   endtask

   initial begin
      int op_idx;
      logic found_end;
      w_en = 1'b0;
      r_en = 1'b0;
      w_data = '0;
      rst_n = 1'b0;
      exp_valid = 1'b0;
      exp_byte = '0;
      lvl_valid = 1'b0;
      exp_level = '0;
      tb_errs = 0;
      found_end = 1'b0;
      $readmemh(GOLDEN_FILE, gold);
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      op_idx = 0;
      while (op_idx < MAX_OPS && !found_end) begin
         if (gold[op_idx*FIELDS][3:0] == OP_END) begin
            found_end = 1'b1;
         end else begin
            run_line(gold[op_idx*FIELDS][3:0], int'(gold[op_idx*FIELDS+1]),
                     gold[op_idx*FIELDS+2], r_byte_t'(gold[op_idx*FIELDS+3]),
                     level_t'(gold[op_idx*FIELDS+4]));
            op_idx++;
         end
      end
      if (!found_end) begin
         $display("golden file is missing or has no end marker");
         tb_errs++;
      end
      // every expected byte has been read by now
      if (pending != 0) begin
         $display("%0d expected bytes were never read", pending);
         tb_errs++;
      end
      repeat (2) idle_cycle();
      assert_fails = i_fifo_sync_asym.i_fifo_sync_asym_chk.fail_cnt;
      $display("checks done: %0d monitor errors, %0d assertion failures, %0d testbench errors",
               mon_errs, assert_fails, tb_errs);
      if (mon_errs == 0 && assert_fails == 0 && tb_errs == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== tb_fifo_monitor.sv ====
`timescale 1ns/1ps

module tb_fifo_monitor
   import fifo_geom_pkg::*;
   import fifo_types_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    w_en,
   input  logic    r_en,
   input  logic    w_full,
   input  logic    r_empty,
   input  level_t  w_level,
   input  level_t  r_level,
   input  r_byte_t r_data,
   input  logic    exp_valid,
   input  r_byte_t exp_byte,
   input  logic    lvl_valid,
   input  level_t  exp_level,
   output int      err_cnt,
   output int      pending
);

   // bytes announced by the stimulus in order
   r_byte_t exp_q[$];

   // reference model of the FIFO state
   int      model_lvl;
   r_byte_t model_rdata;
   logic    push;
   logic    pop;

   // golden file level due at the next sample
   logic    golden_due;
   level_t  golden_lvl;

   initial begin
      err_cnt = 0;
      pending = 0;
   end

   // full once fewer than RATIO byte slots are free
   function automatic logic full_expected(input int lvl);
      return (DEPTH - lvl) < RATIO;
   endfunction

   task automatic flag_mismatch(input string what, input int got, input int want);
      $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
      err_cnt++;
   endtask

   task automatic compare_outputs();
      if (w_level !== level_t'(model_lvl))
         flag_mismatch("w_level", int'(w_level), model_lvl);
      if (r_level !== level_t'(model_lvl))
         flag_mismatch("r_level", int'(r_level), model_lvl);
      if (w_full !== full_expected(model_lvl))
         flag_mismatch("w_full", int'(w_full), int'(full_expected(model_lvl)));
      if (r_empty !== (model_lvl == 0))
         flag_mismatch("r_empty", int'(r_empty), int'(model_lvl == 0));
      if (r_data !== model_rdata)
         flag_mismatch("r_data", int'(r_data), int'(model_rdata));
      if (golden_due && w_level !== golden_lvl)
         flag_mismatch("golden level", int'(w_level), int'(golden_lvl));
   endtask

   // inputs and registered outputs are both settled at the falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         model_lvl = 0;
         model_rdata = '0;
         exp_q.delete();
         golden_due = 1'b0;
      end else begin
         compare_outputs();
         if (exp_valid)
            exp_q.push_back(exp_byte);
         push = w_en && !full_expected(model_lvl);
         pop = r_en && (model_lvl != 0);
         if (pop) begin
            if (exp_q.size() == 0) begin
               $display("** Error at %0d ns: read accepted with no byte expected", $time);
               err_cnt++;
            end else begin
               model_rdata = exp_q.pop_front();
            end
         end
         model_lvl = model_lvl + (push ? RATIO : 0) - (pop ? 1 : 0);
         golden_due = lvl_valid;
         golden_lvl = exp_level;
      end
      pending = exp_q.size();
   end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk
);

   // 4 ns period
   localparam int HALF_NS = 2;

   initial begin
      clk = 1'b0;
   end

   always #HALF_NS clk = ~clk;

endmodule

// ==== fifo_sync_asym_chk.sv ====
`timescale 1ns/1ps

module fifo_sync_asym_chk
   import fifo_geom_pkg::*;
   import fifo_types_pkg::*;
(
   input logic   clk,
   input logic   rst_n,
   input logic   full,
   input logic   empty,
   input logic   w_push,
   input logic   r_pop,
   input level_t level
);

   int fail_cnt = 0;

   a_flags_apart: assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
      else begin
         $error("full and empty set together");
         fail_cnt++;
      end

   a_level_bound: assert property (@(posedge clk) disable iff (!rst_n)
                                   level <= level_t'(DEPTH))
      else begin
         $error("level above DEPTH");
         fail_cnt++;
      end

   a_empty_zero: assert property (@(posedge clk) disable iff (!rst_n) empty |-> level == '0)
      else begin
         $error("empty with a nonzero level");
         fail_cnt++;
      end

   // idle cycle keeps the level
   a_level_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                  (!w_push && !r_pop) |=> $stable(level))
      else begin
         $error("level moved without push or pop");
         fail_cnt++;
      end

endmodule

// ==== fifo_sync_asym.sv ====
`timescale 1ns/1ps

module fifo_sync_asym
   import fifo_types_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,

   // write side, 32-bit words
   input  logic    w_en,
   input  w_word_t w_data,
   output logic    w_full,
   output level_t  w_level,

   // read side, bytes
   input  logic    r_en,
   output r_byte_t r_data,
   output logic    r_empty,
   output level_t  r_level
);

   // gated write and word pointer
   logic    w_push;
   w_addr_t w_addr;
   level_t  w_ptr_b;

   // gated read and byte pointer
   logic    r_pop;
   r_addr_t r_addr;
   level_t  r_ptr;

   // status shared by both sides
   logic    full;
   logic    empty;
   level_t  level;

   fifo_wr_ptr i_fifo_wr_ptr (
      .clk     (clk),
      .rst_n   (rst_n),
      .w_en    (w_en),
      .full    (full),
      .w_push  (w_push),
      .w_addr  (w_addr),
      .w_ptr_b (w_ptr_b)
   );

   fifo_rd_ptr i_fifo_rd_ptr (
      .clk    (clk),
      .rst_n  (rst_n),
      .r_en   (r_en),
      .empty  (empty),
      .r_pop  (r_pop),
      .r_addr (r_addr),
      .r_ptr  (r_ptr)
   );

   fifo_level_flags i_fifo_level_flags (
      .clk     (clk),
      .rst_n   (rst_n),
      .w_push  (w_push),
      .r_pop   (r_pop),
      .w_ptr_b (w_ptr_b),
      .r_ptr   (r_ptr),
      .level   (level),
      .full    (full),
      .empty   (empty)
   );

   fifo_ram_2p_asym i_fifo_ram_2p_asym (
      .clk    (clk),
      .rst_n  (rst_n),
      .w_push (w_push),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_pop  (r_pop),
      .r_addr (r_addr),
      .r_data (r_data)
   );

   // one level, seen from both sides
   assign w_level = level;
   assign r_level = level;

   assign w_full = full;
   assign r_empty = empty;

endmodule

// ==== fifo_ram_2p_asym.sv ====
`timescale 1ns/1ps

module fifo_ram_2p_asym
   import fifo_geom_pkg::*;
   import fifo_types_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    w_push,
   input  w_addr_t w_addr,
   input  w_word_t w_data,
   input  logic    r_pop,
   input  r_addr_t r_addr,
   output r_byte_t r_data
);

   // storage organised in bytes
   r_byte_t mem [DEPTH];

   // first byte slot of the addressed word
   r_addr_t w_base;

   assign w_base = r_addr_t'(w_addr) << (ADDR_W - W_ADDR_W);

   // whole word lands in RATIO neighbouring byte slots
   // lsb at the lowest address so it leaves first
   always_ff @(posedge clk) begin
      if (w_push) begin
         for (int i = 0; i < RATIO; i++) begin
            mem[w_base + r_addr_t'(i)] <= w_data[i*R_DATA_W +: R_DATA_W];
         end
      end
   end

   // registered read port, one cycle latency
   // holds the last popped byte until the next pop
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_data <= '0;
      end else if (r_pop) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

// ==== fifo_level_flags.sv ====
`timescale 1ns/1ps

module fifo_level_flags
   import fifo_geom_pkg::*;
   import fifo_types_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   w_push,
   input  logic   r_pop,
   input  level_t w_ptr_b,
   input  level_t r_ptr,
   output level_t level,
   output logic   full,
   output logic   empty
);

   // contribution of this cycle's accepted operations
   level_t push_inc;
   level_t pop_dec;

   // level as it will be after the coming edge
   level_t level_nxt;

   logic full_nxt;
   logic empty_nxt;

   // both pointers in bytes, modular difference
   // the lap bit keeps 0 and DEPTH apart
   assign level = w_ptr_b - r_ptr;

   // a push brings a whole word, a pop takes one byte
   assign push_inc = w_push ? level_t'(RATIO) : '0;
   assign pop_dec = r_pop ? level_t'(1) : '0;

   // push and pop on the same edge both apply
   assign level_nxt = level + push_inc - pop_dec;

   // full once a whole word no longer fits
   assign full_nxt = level_nxt > level_t'(DEPTH - RATIO);

   // nothing left to pop
   assign empty_nxt = level_nxt == '0;

   // flags track the pointers edge for edge
   // so they are exact one cycle after each operation
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full <= 1'b0;
         empty <= 1'b1;
      end else begin
         full <= full_nxt;
         empty <= empty_nxt;
      end
   end

endmodule

// ==== fifo_rd_ptr.sv ====
`timescale 1ns/1ps

module fifo_rd_ptr
   import fifo_geom_pkg::*;
   import fifo_types_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    r_en,
   input  logic    empty,
   output logic    r_pop,
   output r_addr_t r_addr,
   output level_t  r_ptr
);

   // byte counter, top bit counts laps
   level_t r_cnt;

   // a read while empty is ignored
   assign r_pop = r_en & ~empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_cnt <= '0;
      end else if (r_pop) begin
         r_cnt <= r_cnt + 1'b1;
      end
   end

   // byte slot for the memory read port
   assign r_addr = r_cnt[ADDR_W-1:0];

   // full counter for the level computation
   assign r_ptr = r_cnt;

endmodule

// ==== fifo_wr_ptr.sv ====
`timescale 1ns/1ps

module fifo_wr_ptr
   import fifo_geom_pkg::*;
   import fifo_types_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    w_en,
   input  logic    full,
   output logic    w_push,
   output w_addr_t w_addr,
   output level_t  w_ptr_b
);

   // word counter with one lap bit above the address
   logic [W_ADDR_W:0] w_cnt;

   // a write while full is dropped here, the caller retries
   assign w_push = w_en & ~full;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_cnt <= '0;
      end else if (w_push) begin
         w_cnt <= w_cnt + 1'b1;
      end
   end

   // low bits pick the word slot
   assign w_addr = w_cnt[W_ADDR_W-1:0];

   // same counter in byte units for the level subtraction
   // lap bit lands on the top bit of level_t
   assign w_ptr_b = level_t'(w_cnt) << (ADDR_W - W_ADDR_W);

endmodule

// ==== fifo_types_pkg.sv ====
package fifo_types_pkg;

   import fifo_geom_pkg::*;

   // one word on the write port
   typedef logic [W_DATA_W-1:0] w_word_t;

   // one byte on the read port
   typedef logic [R_DATA_W-1:0] r_byte_t;

   // word slot in the storage array
   typedef logic [W_ADDR_W-1:0] w_addr_t;

   // byte slot in the storage array
   typedef logic [ADDR_W-1:0] r_addr_t;

   // bytes held, one bit wider so a full FIFO reads as DEPTH
   // also used for the lapped pointers in byte units
   typedef logic [ADDR_W:0] level_t;

endpackage

// ==== fifo_geom_pkg.sv ====
package fifo_geom_pkg;

   // word pushed by the writer
   localparam int W_DATA_W = 32;

   // byte popped by the reader
   localparam int R_DATA_W = 8;

   // bytes carried by one write word
   localparam int RATIO = W_DATA_W / R_DATA_W;

   // byte address into the storage array
   localparam int ADDR_W = 6;

   // word address, the byte address without its lane bits
   localparam int W_ADDR_W = ADDR_W - $clog2(RATIO);

   // capacity counted in bytes
   localparam int DEPTH = 1 << ADDR_W;

endpackage
